/* src.f */
+incdir+include
+incdir+verification
src/controlUnitPkg.sv
src/instructionDecoder.sv
src/controlSequencer.sv
src/controlSignalGenerator.sv
src/controlUnit.sv
verification/controlUnit_assertions.sv
verification/controlUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=controlUnitSim

verilator --binary --timing --assert -f src.f --top-module controlUnitTb \
    -Mdir obj_dir -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verification/controlUnitModel.svh */
`ifndef CONTROLUNITMODEL_SVH
`define CONTROLUNITMODEL_SVH

// ========================================
// Control word layout, gra at bit 0
// ========================================
typedef enum int {
    iGra, iGrb, iGrc, iRin, iRout, iBaOut, iPcOut, iIncPc, iPcEn, iIrEn,
    iYIn, iCOut, iZLowOut, iZIn, iMdrOut, iMdrIn, iMarIn, iMemRead, iMemWrite, iConIn
} controlBit_t;

logic [31:0] lcgState = 32'd44; // Fixed seed

function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants
    return lcgState;
endfunction

function automatic logic [19:0] oneHot(input int i);
    return 20'b1 << i;
endfunction

// ========================================
// Instruction classes from the ISA
// ========================================
function automatic instrClass_t classOf(input logic [4:0] op);
    case (op)
        opLd:    return classLoad;
        opLdi:   return classLoadImm;
        opSt:    return classStore;
        opAdd, opSub, opShr, opShra, opShl, opRor, opRol, opAnd, opOr: return classAluReg;
        opAddi, opAndi, opOri: return classAluImm;
        opNeg, opNot: return classUnary;
        opBr:    return classBranch;
        opHalt:  return classHalt;
        default: return classNop; // Dropped and unused codes
    endcase
endfunction

function automatic aluOp_t aluOf(input logic [4:0] op);
    case (op)
        opLd, opLdi, opSt, opAdd, opAddi, opBr: return aluAdd; // Address and target forming
        opSub:        return aluSub;
        opShr:        return aluShr;
        opShra:       return aluShra;
        opShl:        return aluShl;
        opRor:        return aluRor;
        opRol:        return aluRol;
        opAnd, opAndi: return aluAnd;
        opOr, opOri:  return aluOr;
        opNeg:        return aluNeg;
        opNot:        return aluNot;
        default:      return aluNone;
    endcase
endfunction

// Execute cycles per class
function automatic int lengthOf(input instrClass_t cls);
    case (cls)
        classLoad, classStore, classBranch:     return 5;
        classLoadImm, classAluReg, classAluImm: return 3;
        classUnary:                             return 2;
        default:                                return 1; // Nop
    endcase
endfunction

// ========================================
// Expected words per step
// ========================================
function automatic logic [19:0] executeWord(input instrClass_t cls, input int step,
                                            input logic conFf);
    case (cls)
        classLoad, classLoadImm, classStore: begin
            case (step)
                0: return oneHot(iGrb) | oneHot(iBaOut) | oneHot(iRout) | oneHot(iYIn);
                1: return oneHot(iCOut) | oneHot(iZIn);
                2: return (cls == classLoadImm) ? oneHot(iZLowOut) | oneHot(iGra) | oneHot(iRin)
                                                : oneHot(iZLowOut) | oneHot(iMarIn);
                3: return (cls == classStore) ? oneHot(iGra) | oneHot(iRout) | oneHot(iMdrIn)
                                              : oneHot(iMemRead) | oneHot(iMdrIn);
                4: return (cls == classStore) ? oneHot(iMemWrite)
                                              : oneHot(iMdrOut) | oneHot(iGra) | oneHot(iRin);
                default: return '0;
            endcase
        end
        classAluReg, classAluImm: begin
            case (step)
                0: return oneHot(iGrb) | oneHot(iRout) | oneHot(iYIn);
                1: return (cls == classAluReg) ? oneHot(iGrc) | oneHot(iRout) | oneHot(iZIn)
                                               : oneHot(iCOut) | oneHot(iZIn);
                2: return oneHot(iZLowOut) | oneHot(iGra) | oneHot(iRin);
                default: return '0;
            endcase
        end
        classUnary: begin
            case (step)
                0: return oneHot(iGrb) | oneHot(iRout) | oneHot(iZIn);
                1: return oneHot(iZLowOut) | oneHot(iGra) | oneHot(iRin);
                default: return '0;
            endcase
        end
        classBranch: begin
            case (step)
                1: return oneHot(iGra) | oneHot(iRout) | oneHot(iConIn);
                2: return oneHot(iPcOut) | oneHot(iYIn);
                3: return oneHot(iCOut) | oneHot(iZIn);
                4: return oneHot(iZLowOut) | (conFf ? oneHot(iPcEn) : 20'b0); // Taken branch
                default: return '0; // Step 0 is empty
            endcase
        end
        default: return '0; // Nop step
    endcase
endfunction

function automatic logic [19:0] expectedWord(input phase_t ph, input int step,
                                             input instrClass_t cls, input logic conFf);
    case (ph)
        phFetch0:  return oneHot(iPcOut) | oneHot(iMarIn) | oneHot(iIncPc) | oneHot(iZIn);
        phFetch1:  return oneHot(iZLowOut) | oneHot(iPcEn) | oneHot(iMemRead) | oneHot(iMdrIn);
        phFetch2:  return oneHot(iMdrOut) | oneHot(iIrEn);
        phExecute: return executeWord(cls, step, conFf);
        default:   return '0; // Restart, decode, halted
    endcase
endfunction

function automatic aluOp_t expectedAlu(input phase_t ph, input int step,
                                       input instrClass_t cls, input aluOp_t alu);
    if (ph != phExecute) begin
        return aluNone;
    end
    case (cls)
        classLoad, classLoadImm, classStore, classAluReg, classAluImm:
            return (step == 1) ? alu : aluNone;
        classUnary:  return (step == 0) ? alu : aluNone;
        classBranch: return (step == 3) ? aluAdd : aluNone; // Target sum
        default:     return aluNone;
    endcase
endfunction

`endif

/* verification/controlUnitTb.sv */
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlUnitTb import controlUnitPkg::*; ();

    logic                     clock, reset, stop, conFfOut;
    logic [`CU_WORD_WIDTH-1:0] ir;
    logic                     gra, grb, grc, rin, rout, baOut;
    logic                     pcOut, incPc, pcEn, irEn;
    logic                     yIn, cOut, zLowOut, zIn;
    logic                     mdrOut, mdrIn, marIn;
    logic                     memRead, memWrite, conIn, run;
    aluOp_t                   aluOpcode;

    `include "controlUnitModel.svh"

    logic [19:0] actualWord; // Same bit order as controlBit_t
    string signalNames [20] = '{
        "gra", "grb", "grc", "rin", "rout", "baOut", "pcOut", "incPc", "pcEn", "irEn",
        "yIn", "cOut", "zLowOut", "zIn", "mdrOut", "mdrIn", "marIn", "memRead",
        "memWrite", "conIn"
    };

    phase_t      expPhase = phRestart; // Model state
    int          expStep = 0;
    instrClass_t expClass = classNop;
    aluOp_t      expAlu = aluNone;

    int   resetCycles = 7;   // Cycles of reset still to drive
    int   haltedCycles = 0;
    int   checkErrors = 0;
    int   timeoutErrors = 0;
    logic stopPending = 1'b0;

    assign actualWord = {conIn, memWrite, memRead, marIn, mdrIn, mdrOut, zIn, zLowOut, cOut,
                         yIn, irEn, pcEn, incPc, pcOut, baOut, rout, rin, grc, grb, gra};

    controlUnit UUT (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock; // 10 ns period
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            checkErrors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkAluOp(input aluOp_t expected, input aluOp_t actual);
        if (actual !== expected) begin
            checkErrors++;
            $display("CHECK FAILED aluOpcode expected %h actual %h at %0t", expected, actual,
                     $time);
        end
    endtask

    task automatic checkRun(input logic expected, input logic actual);
        if (actual !== expected) begin
            checkErrors++;
            $display("CHECK FAILED run expected %h actual %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic compareOutputs();
        logic [19:0] expWord;
        expWord = expectedWord(expPhase, expStep, expClass, conFfOut); // Flag from last drive
        for (int i = 0; i < 20; i++) begin
            checkBit(signalNames[i], expWord[i], actualWord[i]);
        end
        checkAluOp(expectedAlu(expPhase, expStep, expClass, expAlu), aluOpcode);
        checkRun(expPhase != phHalted, run);
    endtask

    // Next phase as the DUT sees the inputs at the coming rising edge
    task automatic advanceModel();
        if (reset) begin
            expPhase = phRestart;
            expStep  = 0;
        end else if (stop) begin
            expPhase = phHalted;
        end else begin
            case (expPhase)
                phRestart: expPhase = phFetch0;
                phFetch0:  expPhase = phFetch1;
                phFetch1:  expPhase = phFetch2;
                phFetch2:  expPhase = phDecode;
                phDecode: begin
                    expClass = classOf(ir[`CU_OPCODE_MSB:`CU_OPCODE_LSB]);
                    expAlu   = aluOf(ir[`CU_OPCODE_MSB:`CU_OPCODE_LSB]);
                    expStep  = 0;
                    expPhase = (expClass == classHalt) ? phHalted : phExecute;
                end
                phExecute: begin
                    if (expStep == lengthOf(expClass) - 1) begin
                        expPhase = phRestart;
                        expStep  = 0;
                    end else begin
                        expStep++;
                    end
                end
                default: ; // Halted until reset
            endcase
        end
    endtask

    // ========================================
    // One cycle: check, drive, step model
    // ========================================
    task automatic runCycle();
        logic [31:0] rnd;
        @(negedge clock);
        compareOutputs();
        reset = (resetCycles != 0);
        if (resetCycles != 0) begin
            resetCycles--;
        end
        stop        = stopPending; // One cycle pulse
        stopPending = 1'b0;
        rnd         = lcgNext();
        conFfOut    = rnd[31];
        if (expPhase == phFetch2) begin
            ir = lcgNext(); // New instruction while irEn is high
        end
        advanceModel();
        if (expPhase == phHalted) begin
            haltedCycles++;
        end else begin
            haltedCycles = 0;
        end
        if (haltedCycles == 6 && resetCycles == 0) begin
            resetCycles = 8; // Leave halt through reset
        end
    endtask

    task automatic waitForRunLow(input int limit);
        int count;
        count = 0;
        while (run !== 1'b0 && count < limit) begin
            runCycle();
            count++;
        end
        if (run !== 1'b0) begin
            timeoutErrors++;
            $display("Timeout: run did not fall within %0d cycles after stop", limit);
        end
    endtask

    task automatic waitForFetch(input int limit);
        int count;
        count = 0;
        while (!(pcOut === 1'b1 && marIn === 1'b1) && count < limit) begin
            runCycle();
            count++;
        end
        if (!(pcOut === 1'b1 && marIn === 1'b1)) begin
            timeoutErrors++;
            $display("Timeout: fetch did not start within %0d cycles", limit);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        reset    = 1'b1;
        stop     = 1'b0;
        ir       = '0;
        conFfOut = 1'b0;
        for (int i = 0; i < 2000; i++) begin
            runCycle(); // Random instructions, random halts recover via reset
        end
        waitForFetch(40); // Running and out of reset before the stop pulse
        stopPending = 1'b1;
        waitForRunLow(6);
        waitForFetch(40);
        for (int i = 0; i < 100; i++) begin
            runCycle();
        end
        $display("Errors: %0d check mismatches, %0d timeouts", checkErrors, timeoutErrors);
        if (checkErrors + timeoutErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #100000; // Far beyond the expected run length
        $display("Watchdog expired before the test sequence finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verification/controlUnit_assertions.sv */
`timescale 1ns/1ps

module controlUnit_assertions (
    input logic clock,
    input logic reset,
    input logic gra,
    input logic grb,
    input logic grc,
    input logic memRead,
    input logic memWrite,
    input logic irEn,
    input logic cOut,
    input logic zLowOut,
    input logic run
);

    // ========================================
    // Datapath safety rules
    // ========================================
    assert property (@(posedge clock) disable iff (reset) !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    assert property (@(posedge clock) disable iff (reset) $onehot0({gra, grb, grc}))
        else $error("More than one register select high"); // Bus contention on register file

    assert property (@(posedge clock) disable iff (reset) !run |-> !irEn)
        else $error("irEn high while halted");

    assert property (@(posedge clock) disable iff (reset) !(cOut && zLowOut))
        else $error("cOut and zLowOut both drive the bus");

endmodule

bind controlUnit controlUnit_assertions protocolChecks (
    .clock(clock), .reset(reset),
    .gra(gra), .grb(grb), .grc(grc),
    .memRead(memRead), .memWrite(memWrite),
    .irEn(irEn), .cOut(cOut), .zLowOut(zLowOut), .run(run)
);

/* src/controlUnit.sv */
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlUnit import controlUnitPkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     stop,
    input  logic [`CU_WORD_WIDTH-1:0] ir,
    input  logic                     conFfOut,
    output logic                     gra, grb, grc, rin, rout, baOut,
    output logic                     pcOut, incPc, pcEn, irEn,
    output logic                     yIn, cOut, zLowOut, zIn,
    output logic                     mdrOut, mdrIn, marIn,
    output logic                     memRead, memWrite, conIn,
    output logic                     run,
    output aluOp_t                   aluOpcode
);

    instrClass_t               decodedClass; // Decoder to sequencer
    aluOp_t                    decodedAluOp;
    phase_t                    phase;        // Sequencer to generator
    logic [`CU_STEP_WIDTH-1:0] execStep;
    instrClass_t               instrClass;
    aluOp_t                    aluOp;

    instructionDecoder decoder (.*);

    controlSequencer sequencer (.*);

    controlSignalGenerator generator (.*); // Drives every control port

endmodule

/* src/controlSignalGenerator.sv */
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlSignalGenerator import controlUnitPkg::*; (
    input  phase_t                    phase,
    input  logic [`CU_STEP_WIDTH-1:0] execStep,
    input  instrClass_t               instrClass,
    input  aluOp_t                    aluOp,
    input  logic                      conFfOut,                   // Branch condition flag
    output logic                      gra, grb, grc, rin, rout,   // Register file select
    output logic                      baOut,
    output logic                      pcOut, incPc, pcEn, irEn,   // PC and IR
    output logic                      yIn, cOut, zLowOut, zIn,    // ALU operand and result
    output logic                      mdrOut, mdrIn, marIn,       // Memory interface
    output logic                      memRead, memWrite,
    output logic                      conIn,
    output logic                      run,
    output aluOp_t                    aluOpcode
);

    // ========================================
    // Moore word per phase and step
    // ========================================
    always_comb begin
        {gra, grb, grc, rin, rout, baOut} = '0;
        {pcOut, incPc, pcEn, irEn}        = '0;
        {yIn, cOut, zLowOut, zIn}         = '0;
        {mdrOut, mdrIn, marIn}            = '0;
        {memRead, memWrite, conIn}        = '0;
        run       = (phase != phHalted);
        aluOpcode = aluNone;
        case (phase)
            phFetch0: begin
                pcOut = 1'b1; // PC to MAR and Y path
                marIn = 1'b1;
                incPc = 1'b1;
                zIn   = 1'b1;
            end
            phFetch1: begin
                zLowOut = 1'b1; // PC plus one back into PC
                pcEn    = 1'b1;
                memRead = 1'b1;
                mdrIn   = 1'b1;
            end
            phFetch2: begin
                mdrOut = 1'b1; // Instruction into IR
                irEn   = 1'b1;
            end
            phExecute: begin
                case (instrClass)
                    classLoad, classLoadImm, classStore: begin
                        case (execStep)
                            3'd0: begin
                                grb   = 1'b1; // Base register into Y
                                baOut = 1'b1;
                                rout  = 1'b1;
                                yIn   = 1'b1;
                            end
                            3'd1: begin
                                cOut      = 1'b1; // Plus sign extended constant
                                zIn       = 1'b1;
                                aluOpcode = aluOp;
                            end
                            3'd2: begin
                                zLowOut = 1'b1;
                                if (instrClass == classLoadImm) begin
                                    gra = 1'b1; // Sum is the value
                                    rin = 1'b1;
                                end else begin
                                    marIn = 1'b1; // Sum is the address
                                end
                            end
                            3'd3: begin
                                mdrIn = 1'b1;
                                if (instrClass == classStore) begin
                                    gra  = 1'b1; // Ra into MDR
                                    rout = 1'b1;
                                end else begin
                                    memRead = 1'b1;
                                end
                            end
                            3'd4: begin
                                if (instrClass == classStore) begin
                                    memWrite = 1'b1;
                                end else begin
                                    mdrOut = 1'b1; // Loaded word into Ra
                                    gra    = 1'b1;
                                    rin    = 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                    classAluReg, classAluImm: begin
                        case (execStep)
                            3'd0: begin
                                grb  = 1'b1; // Rb into Y
                                rout = 1'b1;
                                yIn  = 1'b1;
                            end
                            3'd1: begin
                                zIn       = 1'b1;
                                aluOpcode = aluOp;
                                if (instrClass == classAluReg) begin
                                    grc  = 1'b1; // Rc as second operand
                                    rout = 1'b1;
                                end else begin
                                    cOut = 1'b1; // Constant as second operand
                                end
                            end
                            3'd2: begin
                                zLowOut = 1'b1;
                                gra     = 1'b1;
                                rin     = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    classUnary: begin
                        if (execStep == 3'd0) begin
                            grb       = 1'b1; // Single operand straight to ALU
                            rout      = 1'b1;
                            zIn       = 1'b1;
                            aluOpcode = aluOp;
                        end else begin
                            zLowOut = 1'b1;
                            gra     = 1'b1;
                            rin     = 1'b1;
                        end
                    end
                    classBranch: begin
                        case (execStep)
                            3'd1: begin
                                gra   = 1'b1; // Ra tested by CON logic
                                rout  = 1'b1;
                                conIn = 1'b1;
                            end
                            3'd2: begin
                                pcOut = 1'b1;
                                yIn   = 1'b1;
                            end
                            3'd3: begin
                                cOut      = 1'b1; // Target address
                                zIn       = 1'b1;
                                aluOpcode = aluAdd;
                            end
                            3'd4: begin
                                zLowOut = 1'b1;
                                pcEn    = conFfOut; // Taken only when flag set
                            end
                            default: ;
                        endcase
                    end
                    default: ; // Nop step is empty
                endcase
            end
            default: ; // Restart, decode and halted words are empty
        endcase
    end

endmodule

/* src/controlSequencer.sv */
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlSequencer import controlUnitPkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stop,         // Level sampled every edge
    input  instrClass_t               decodedClass,
    input  aluOp_t                    decodedAluOp,
    output phase_t                    phase,
    output logic [`CU_STEP_WIDTH-1:0] execStep,
    output instrClass_t               instrClass,   // Latched at end of decode
    output aluOp_t                    aluOp
);

    phase_t                    phaseNext;
    logic [`CU_STEP_WIDTH-1:0] stepNext;
    logic                      lastExec;

    // Index of the final execute step per class
    function automatic logic [`CU_STEP_WIDTH-1:0] lastStep(input instrClass_t cls);
        case (cls)
            classLoad:    lastStep = 3'd4;
            classStore:   lastStep = 3'd4;
            classBranch:  lastStep = 3'd4;
            classLoadImm: lastStep = 3'd2;
            classAluReg:  lastStep = 3'd2;
            classAluImm:  lastStep = 3'd2;
            classUnary:   lastStep = 3'd1;
            default:      lastStep = 3'd0; // Nop is one empty step
        endcase
    endfunction

    assign lastExec = (execStep == lastStep(instrClass));

    // ========================================
    // Next phase
    // ========================================
    always_comb begin
        phaseNext = phase;
        stepNext  = execStep;
        if (stop) begin
            phaseNext = phHalted; // Wins over every other move
        end else begin
            case (phase)
                phRestart: phaseNext = phFetch0;
                phFetch0:  phaseNext = phFetch1;
                phFetch1:  phaseNext = phFetch2;
                phFetch2:  phaseNext = phDecode;
                phDecode: begin
                    stepNext  = '0;
                    phaseNext = (decodedClass == classHalt) ? phHalted : phExecute;
                end
                phExecute: begin
                    if (lastExec) begin
                        phaseNext = phRestart; // Instruction done
                        stepNext  = '0;
                    end else begin
                        stepNext = execStep + 1'b1;
                    end
                end
                phHalted: phaseNext = phHalted; // Only reset leaves
                default:  phaseNext = phRestart; // Spare encoding
            endcase
        end
    end

    // ========================================
    // State registers
    // ========================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase    <= phRestart;
            execStep <= '0;
        end else begin
            phase    <= phaseNext;
            execStep <= stepNext;
        end
    end

    // Instruction latch, only read during execute
    always_ff @(posedge clock) begin
        if (phase == phDecode) begin
            instrClass <= decodedClass;
            aluOp      <= decodedAluOp;
        end
    end

endmodule

/* src/instructionDecoder.sv */
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module instructionDecoder import controlUnitPkg::*; (
    input  logic [`CU_WORD_WIDTH-1:0] ir,
    output instrClass_t               decodedClass,
    output aluOp_t                    decodedAluOp
);

    opcode_t opcode;

    assign opcode = opcode_t'(ir[`CU_OPCODE_MSB:`CU_OPCODE_LSB]); // Codes above halt stay raw

    // ========================================
    // Opcode to class and ALU operation
    // ========================================
    always_comb begin
        decodedClass = classNop; // Dropped and unused codes
        decodedAluOp = aluNone;
        case (opcode)
            opLd: begin
                decodedClass = classLoad;
                decodedAluOp = aluAdd; // Rb plus offset
            end
            opLdi: begin
                decodedClass = classLoadImm;
                decodedAluOp = aluAdd;
            end
            opSt: begin
                decodedClass = classStore;
                decodedAluOp = aluAdd; // Address forming
            end
            opAdd, opSub, opShr, opShra, opShl, opRor, opRol, opAnd, opOr: begin
                decodedClass = classAluReg;
                decodedAluOp = aluOp_t'(opcode); // ALU codes equal the opcodes here
            end
            opAddi: begin
                decodedClass = classAluImm;
                decodedAluOp = aluAdd;
            end
            opAndi: begin
                decodedClass = classAluImm;
                decodedAluOp = aluAnd;
            end
            opOri: begin
                decodedClass = classAluImm;
                decodedAluOp = aluOr;
            end
            opNeg, opNot: begin
                decodedClass = classUnary;
                decodedAluOp = aluOp_t'(opcode); // Same shared encoding
            end
            opBr: begin
                decodedClass = classBranch;
                decodedAluOp = aluAdd; // PC plus displacement
            end
            opHalt: begin
                decodedClass = classHalt;
            end
            default: begin
                decodedClass = classNop;
                decodedAluOp = aluNone;
            end
        endcase
    end

endmodule

/* src/controlUnitPkg.sv */
`include "controlUnit_defines.svh"

package controlUnitPkg;

    // ========================================
    // ISA opcodes in IR[31:27]
    // ========================================
    typedef enum logic [`CU_OPCODE_WIDTH-1:0] {
        opLd = 5'b00000, opLdi, opSt,          // Memory group
        opAdd, opSub,                          // 00011 and 00100
        opShr, opShra, opShl, opRor, opRol,    // Shifts and rotates
        opAnd, opOr,                           // Logic
        opAddi, opAndi, opOri,                 // Immediate group
        opMul, opDiv,                          // Not supported here
        opNeg, opNot,                          // Unary group
        opBr,                                  // Conditional branch
        opJr, opJal, opIn, opOut,              // Not supported here
        opMfhi, opMflo,                        // Not supported here
        opNop, opHalt                          // 11010 and 11011
    } opcode_t;

    // ALU select codes understood by the datapath
    typedef enum logic [`CU_ALU_OP_WIDTH-1:0] {
        aluNone = 5'b00000, // Pass through
        aluAdd  = 5'b00011,
        aluSub  = 5'b00100,
        aluShr  = 5'b00101,
        aluShra = 5'b00110, // Sign preserving
        aluShl  = 5'b00111,
        aluRor  = 5'b01000,
        aluRol  = 5'b01001,
        aluAnd  = 5'b01010,
        aluOr   = 5'b01011,
        aluNeg  = 5'b10001, // Two's complement
        aluNot  = 5'b10010
    } aluOp_t;

    // One sequence of execute words per class
    typedef enum logic [3:0] {
        classLoad, classLoadImm, classStore,
        classAluReg, classAluImm, classUnary,
        classBranch, classNop, classHalt
    } instrClass_t;

    // Sequencer phases
    typedef enum logic [2:0] {
        phRestart, // Idle word with run high
        phFetch0, phFetch1, phFetch2,
        phDecode,  // Class taken from IR here
        phExecute, // Stepped by execStep
        phHalted   // Held until reset
    } phase_t;

endpackage

/* include/controlUnit_defines.svh */
`ifndef CONTROLUNIT_DEFINES_SVH
`define CONTROLUNIT_DEFINES_SVH

// ========================================
// Instruction word layout
// ========================================
`define CU_WORD_WIDTH    32 // IR width
`define CU_OPCODE_MSB    31 // Opcode field top bit
`define CU_OPCODE_LSB    27 // Opcode field bottom bit
`define CU_OPCODE_WIDTH  5  // Opcode field width

`define CU_ALU_OP_WIDTH  5  // ALU select code to datapath
`define CU_STEP_WIDTH    3  // Execute step counter

`endif
